/* common/csr_pkg.sv */
package csr_pkg;

    localparam int DATA_W     = 32;
    localparam int CSR_ADDR_W = 14;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int HWI_W      = 8;
    localparam int INT_W      = 13;

    // crmd fields
    localparam logic [DATA_W-1:0] CRMD_MASK  = 32'h0000_01ff;
    localparam logic [DATA_W-1:0] CRMD_RESET = 32'h0000_0008;
    localparam int CRMD_PLV_MSB = 1;
    localparam int CRMD_IE      = 2;

    // writable fields of the other exception registers
    localparam logic [DATA_W-1:0] PRMD_MASK   = 32'h0000_0007;
    localparam logic [DATA_W-1:0] ECFG_MASK   = 32'h0000_1fff;
    localparam logic [DATA_W-1:0] ESTAT_WMASK = 32'h0000_0003;

    // estat fields
    localparam int ESTAT_HWI_LSB   = 2;
    localparam int ESTAT_TI        = 11;
    localparam int ESTAT_IPI       = 12;
    localparam int ESTAT_ECODE_LSB = 16;
    localparam int ESTAT_ESUB_LSB  = 22;

    // eentry is 64-byte aligned
    localparam int EENTRY_ALIGN = 6;

    // timer fields
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int TICLR_CLR     = 0;

    typedef enum logic [CSR_ADDR_W-1:0] {
        CRMD   = 14'h00,
        PRMD   = 14'h01,
        ECFG   = 14'h04,
        ESTAT  = 14'h05,
        ERA    = 14'h06,
        EENTRY = 14'h0c,
        SAVE0  = 14'h30,
        SAVE1  = 14'h31,
        SAVE2  = 14'h32,
        SAVE3  = 14'h33,
        TID    = 14'h40,
        TCFG   = 14'h41,
        TVAL   = 14'h42,
        TICLR  = 14'h44
    } csr_addr_e;

    typedef struct packed {
        logic                  en;
        logic [CSR_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } csr_wr_t;

    typedef struct packed {
        logic                  except;
        logic                  ertn;
        logic [DATA_W-1:0]     epc;
        logic [ECODE_W-1:0]    ecode;
        logic [ESUBCODE_W-1:0] esubcode;
    } trap_event_t;

    // one strobe per register held outside the access block
    typedef struct packed {
        logic              crmd;
        logic              prmd;
        logic              ecfg;
        logic              estat;
        logic              era;
        logic              eentry;
        logic              tid;
        logic              tcfg;
        logic              ticlr;
        logic [DATA_W-1:0] data;
    } csr_wsel_t;

    typedef struct packed {
        logic [DATA_W-1:0] crmd;
        logic [DATA_W-1:0] prmd;
        logic [DATA_W-1:0] ecfg;
        logic [DATA_W-1:0] estat;
        logic [DATA_W-1:0] era;
        logic [DATA_W-1:0] eentry;
    } trap_view_t;

    typedef struct packed {
        logic [DATA_W-1:0] tid;
        logic [DATA_W-1:0] tcfg;
        logic [DATA_W-1:0] tval;
    } timer_view_t;

endpackage

/* design/csr_access.sv */
`timescale 1ns/1ps

module csr_access (
    input  logic                        clk,
    input  logic                        rst,
    input  csr_pkg::csr_addr_e          raddr,
    input  csr_pkg::csr_wr_t            wr,
    output csr_pkg::csr_wsel_t          wsel,
    input  csr_pkg::trap_view_t         trap_view,
    input  csr_pkg::timer_view_t        timer_view,
    output logic [csr_pkg::DATA_W-1:0]  rdata
);
    import csr_pkg::*;

    logic [DATA_W-1:0] save [4];
    logic [3:0]        save_we;

    // address decode into strobes
    always_comb
    begin
        wsel      = '0;
        wsel.data = wr.data;
        save_we   = '0;
        if (wr.en)
        begin
            case (wr.addr)
                CRMD:    wsel.crmd   = 1'b1;
                PRMD:    wsel.prmd   = 1'b1;
                ECFG:    wsel.ecfg   = 1'b1;
                ESTAT:   wsel.estat  = 1'b1;
                ERA:     wsel.era    = 1'b1;
                EENTRY:  wsel.eentry = 1'b1;
                TID:     wsel.tid    = 1'b1;
                TCFG:    wsel.tcfg   = 1'b1;
                TICLR:   wsel.ticlr  = 1'b1;
                SAVE0:   save_we[0]  = 1'b1;
                SAVE1:   save_we[1]  = 1'b1;
                SAVE2:   save_we[2]  = 1'b1;
                SAVE3:   save_we[3]  = 1'b1;
                default: save_we     = '0;
            endcase
        end
    end

    // scratch registers hold the full word
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (save_we[i])
                save[i] <= wr.data;
        end
    end

    always_comb
    begin
        case (raddr)
            CRMD:    rdata = trap_view.crmd;
            PRMD:    rdata = trap_view.prmd;
            ECFG:    rdata = trap_view.ecfg;
            ESTAT:   rdata = trap_view.estat;
            ERA:     rdata = trap_view.era;
            EENTRY:  rdata = trap_view.eentry;
            SAVE0:   rdata = save[0];
            SAVE1:   rdata = save[1];
            SAVE2:   rdata = save[2];
            SAVE3:   rdata = save[3];
            TID:     rdata = timer_view.tid;
            TCFG:    rdata = timer_view.tcfg;
            TVAL:    rdata = timer_view.tval;
            // ticlr reads as zero
            default: rdata = '0;
        endcase
    end

    a_one_target: assert property (@(posedge clk) disable iff (rst)
        $onehot0({wsel.crmd, wsel.prmd, wsel.ecfg, wsel.estat, wsel.era,
                  wsel.eentry, wsel.tid, wsel.tcfg, wsel.ticlr, save_we}));

endmodule

/* trap/csr_trap.sv */
`timescale 1ns/1ps

module csr_trap (
    input  logic                        clk,
    input  logic                        rst,
    input  csr_pkg::csr_wsel_t          wsel,
    input  csr_pkg::trap_event_t        evt,
    input  logic [csr_pkg::HWI_W-1:0]   hwi,
    input  logic                        ipi,
    input  logic                        timer_irq,
    output csr_pkg::trap_view_t         view,
    output logic                        is_interrupt,
    output logic [csr_pkg::DATA_W-1:0]  trap_entry,
    output logic [csr_pkg::DATA_W-1:0]  era_out,
    output logic [csr_pkg::DATA_W-1:0]  crmd_out
);
    import csr_pkg::*;

    logic [DATA_W-1:0]              crmd;
    logic [DATA_W-1:0]              prmd;
    logic [DATA_W-1:0]              ecfg;
    logic [DATA_W-1:0]              estat;
    logic [DATA_W-1:0]              era;
    logic [DATA_W-1:EENTRY_ALIGN]   eentry_hi;

    // crmd priority is exception over return over write
    always_ff @(posedge clk)
    begin
        if (rst)
            crmd <= CRMD_RESET;
        else if (evt.except)
        begin
            crmd[CRMD_PLV_MSB:0] <= '0;
            crmd[CRMD_IE]        <= 1'b0;
        end
        else if (evt.ertn)
        begin
            crmd[CRMD_PLV_MSB:0] <= prmd[CRMD_PLV_MSB:0];
            crmd[CRMD_IE]        <= prmd[CRMD_IE];
        end
        else if (wsel.crmd)
            crmd <= wsel.data & CRMD_MASK;
    end

    // prmd saves the mode on entry
    always_ff @(posedge clk)
    begin
        if (rst)
            prmd <= '0;
        else if (evt.except)
        begin
            prmd[CRMD_PLV_MSB:0] <= crmd[CRMD_PLV_MSB:0];
            prmd[CRMD_IE]        <= crmd[CRMD_IE];
        end
        else if (wsel.prmd)
            prmd <= wsel.data & PRMD_MASK;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            ecfg <= '0;
        else if (wsel.ecfg)
            ecfg <= wsel.data & ECFG_MASK;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            estat <= '0;
        else
        begin
            // interrupt lines sampled every cycle
            estat[ESTAT_HWI_LSB +: HWI_W] <= hwi;
            estat[ESTAT_TI]               <= timer_irq;
            estat[ESTAT_IPI]              <= ipi;
            if (evt.except)
            begin
                estat[ESTAT_ECODE_LSB +: ECODE_W]   <= evt.ecode;
                estat[ESTAT_ESUB_LSB +: ESUBCODE_W] <= evt.esubcode;
            end
            else if (wsel.estat)
                estat[1:0] <= wsel.data[1:0] & ESTAT_WMASK[1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (evt.except)
            era <= evt.epc;
        else if (wsel.era)
            era <= wsel.data;
    end

    always_ff @(posedge clk)
    begin
        if (wsel.eentry)
            eentry_hi <= wsel.data[DATA_W-1:EENTRY_ALIGN];
    end

    always_comb
    begin
        view.crmd   = crmd;
        view.prmd   = prmd;
        view.ecfg   = ecfg;
        view.estat  = estat;
        view.era    = era;
        view.eentry = {eentry_hi, {EENTRY_ALIGN{1'b0}}};
    end

    assign is_interrupt = crmd[CRMD_IE] & (|(estat[INT_W-1:0] & ecfg[INT_W-1:0]));
    assign trap_entry   = view.eentry;
    assign era_out      = era;
    assign crmd_out     = crmd;

    a_no_except_ertn: assert property (@(posedge clk) disable iff (rst)
        !(evt.except && evt.ertn));

endmodule

/* timer/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_wsel_t     wsel,
    output csr_pkg::timer_view_t   view,
    output logic                   timer_irq
);
    import csr_pkg::*;

    logic [DATA_W-1:0] tid;
    logic [DATA_W-1:0] tcfg;
    logic [DATA_W-1:0] tval;
    logic              timer_en;
    logic              expire;

    assign expire = timer_en && (tval == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tid  <= '0;
            tcfg <= '0;
        end
        else
        begin
            if (wsel.tid)
                tid <= wsel.data;
            if (wsel.tcfg)
                tcfg <= wsel.data;
        end
    end

    // one-shot mode drops enable at expiry
    always_ff @(posedge clk)
    begin
        if (rst)
            timer_en <= 1'b0;
        else if (wsel.tcfg)
            timer_en <= wsel.data[TCFG_EN];
        else if (expire)
            timer_en <= tcfg[TCFG_PERIODIC];
    end

    always_ff @(posedge clk)
    begin
        if (wsel.tcfg)
            tval <= {wsel.data[DATA_W-1:2], 2'b00};
        else if (expire)
            tval <= tcfg[TCFG_PERIODIC] ? {tcfg[DATA_W-1:2], 2'b00} : '1;
        else if (timer_en)
            tval <= tval - 1'b1;
    end

    // clear wins over a new expiry
    always_ff @(posedge clk)
    begin
        if (rst)
            timer_irq <= 1'b0;
        else if (wsel.ticlr && wsel.data[TICLR_CLR])
            timer_irq <= 1'b0;
        else if (expire)
            timer_irq <= 1'b1;
    end

    always_comb
    begin
        view.tid  = tid;
        view.tcfg = tcfg;
        view.tval = tval;
    end

    a_hold_when_off: assert property (@(posedge clk) disable iff (rst)
        (!timer_en && !wsel.tcfg) |=> $stable(tval));

endmodule

/* design/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  csr_pkg::csr_addr_e          raddr,
    output logic [csr_pkg::DATA_W-1:0]  rdata,
    input  csr_pkg::csr_wr_t            wr,
    input  csr_pkg::trap_event_t        evt,
    input  logic [csr_pkg::HWI_W-1:0]   hwi,
    input  logic                        ipi,
    output logic                        is_interrupt,
    output logic [csr_pkg::DATA_W-1:0]  trap_entry,
    output logic [csr_pkg::DATA_W-1:0]  era_out,
    output logic [csr_pkg::DATA_W-1:0]  crmd_out
);
    import csr_pkg::*;

    csr_wsel_t   wsel;
    trap_view_t  trap_view;
    timer_view_t timer_view;
    logic        timer_irq;

    csr_access u_access (
        .clk        (clk),
        .rst        (rst),
        .raddr      (raddr),
        .wr         (wr),
        .wsel       (wsel),
        .trap_view  (trap_view),
        .timer_view (timer_view),
        .rdata      (rdata)
    );

    csr_trap u_trap (
        .clk          (clk),
        .rst          (rst),
        .wsel         (wsel),
        .evt          (evt),
        .hwi          (hwi),
        .ipi          (ipi),
        .timer_irq    (timer_irq),
        .view         (trap_view),
        .is_interrupt (is_interrupt),
        .trap_entry   (trap_entry),
        .era_out      (era_out),
        .crmd_out     (crmd_out)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .wsel      (wsel),
        .view      (timer_view),
        .timer_irq (timer_irq)
    );

endmodule

/* testbench/csr_checker.sv */
`timescale 1ns/1ps

module csr_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  csr_pkg::csr_addr_e          raddr,
    input  csr_pkg::csr_wr_t            wr,
    input  csr_pkg::trap_event_t        evt,
    input  logic [csr_pkg::HWI_W-1:0]   hwi,
    input  logic                        ipi,
    input  logic [csr_pkg::DATA_W-1:0]  rdata,
    input  logic                        is_interrupt,
    input  logic [csr_pkg::DATA_W-1:0]  trap_entry,
    input  logic [csr_pkg::DATA_W-1:0]  era_out,
    input  logic [csr_pkg::DATA_W-1:0]  crmd_out,
    input  int                          test_num,
    input  logic                        finished,
    output int                          error_count
);
    import csr_pkg::*;

    logic [DATA_W-1:0] m_crmd, m_prmd, m_ecfg, m_estat, m_era, m_eentry;
    logic [DATA_W-1:0] m_tid, m_tcfg, m_tval;
    logic [DATA_W-1:0] m_save [4];
    logic              m_en, m_irq;
    // bits of each unreset register that hold a known value
    logic [DATA_W-1:0] era_known = '0;
    logic [DATA_W-1:0] eentry_known = 32'h0000_003f;
    logic [DATA_W-1:0] tval_known = '0;
    logic [DATA_W-1:0] save_known [4] = '{'0, '0, '0, '0};
    int cur_test = 0;
    int tests_done = 0;
    int check_count = 0;
    int test_checks = 0;
    int test_errors = 0;
    logic reported = 1'b0;

    initial
        error_count = 0;

    function automatic string test_name(input int n);
        case (n)
            1: return "reset values";
            2: return "register access";
            3: return "exception and return";
            4: return "hardware and ipi interrupts";
            5: return "timer";
            default: return "unnamed";
        endcase
    endfunction

    task check_value(input string name, input logic [DATA_W-1:0] exp,
                     input logic [DATA_W-1:0] act, input logic [DATA_W-1:0] mask);
        check_count++;
        test_checks++;
        if ((act & mask) !== (exp & mask))
        begin
            error_count++;
            test_errors++;
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp & mask, act & mask);
        end
    endtask

    task read_model(input logic [CSR_ADDR_W-1:0] addr, output logic [DATA_W-1:0] val,
                    output logic [DATA_W-1:0] mask);
        case (addr)
            CRMD:    val = m_crmd;
            PRMD:    val = m_prmd;
            ECFG:    val = m_ecfg;
            ESTAT:   val = m_estat;
            ERA:     val = m_era;
            EENTRY:  val = m_eentry;
            SAVE0:   val = m_save[0];
            SAVE1:   val = m_save[1];
            SAVE2:   val = m_save[2];
            SAVE3:   val = m_save[3];
            TID:     val = m_tid;
            TCFG:    val = m_tcfg;
            TVAL:    val = m_tval;
            default: val = '0;
        endcase
        // unreset registers only where written
        case (addr)
            ERA:     mask = era_known;
            EENTRY:  mask = eentry_known;
            SAVE0:   mask = save_known[0];
            SAVE1:   mask = save_known[1];
            SAVE2:   mask = save_known[2];
            SAVE3:   mask = save_known[3];
            TVAL:    mask = tval_known;
            default: mask = '1;
        endcase
    endtask

    task compare_outputs;
        logic [DATA_W-1:0] val;
        logic [DATA_W-1:0] mask;
        logic              pending;
        logic              irq_exp;
        read_model(raddr, val, mask);
        check_value("rdata", val, rdata, mask);
        pending = 1'b0;
        for (int b = 0; b < INT_W; b++)
        begin
            if (m_estat[b] && m_ecfg[b])
                pending = 1'b1;
        end
        irq_exp = m_crmd[CRMD_IE] && pending;
        check_value("is_interrupt", {31'd0, irq_exp}, {31'd0, is_interrupt}, 32'd1);
        check_value("trap_entry", m_eentry, trap_entry, eentry_known);
        check_value("era_out", m_era, era_out, era_known);
        check_value("crmd_out", m_crmd, crmd_out, '1);
    endtask

    task reset_model;
        m_crmd  = CRMD_RESET;
        m_prmd  = '0;
        m_ecfg  = '0;
        m_estat = '0;
        m_tid   = '0;
        m_tcfg  = '0;
        m_en    = 1'b0;
        m_irq   = 1'b0;
    endtask

    // next state from the register rules using the old values
    task update_model;
        logic [DATA_W-1:0] old_crmd, old_prmd, old_tcfg;
        logic              expire;
        old_crmd = m_crmd;
        old_prmd = m_prmd;
        old_tcfg = m_tcfg;
        expire = m_en && (tval_known == '1) && (m_tval == '0);
        if (evt.except)
            m_crmd[2:0] = 3'b000;
        else if (evt.ertn)
            m_crmd[2:0] = old_prmd[2:0];
        else if (wr.en && wr.addr == CRMD)
            m_crmd = wr.data & CRMD_MASK;
        if (evt.except)
            m_prmd[2:0] = old_crmd[2:0];
        else if (wr.en && wr.addr == PRMD)
            m_prmd = wr.data & PRMD_MASK;
        if (wr.en && wr.addr == ECFG)
            m_ecfg = wr.data & ECFG_MASK;
        m_estat[9:2] = hwi;
        m_estat[11]  = m_irq;
        m_estat[12]  = ipi;
        if (evt.except)
        begin
            m_estat[21:16] = evt.ecode;
            m_estat[30:22] = evt.esubcode;
        end
        else if (wr.en && wr.addr == ESTAT)
            m_estat[1:0] = wr.data[1:0];
        if (evt.except || (wr.en && wr.addr == ERA))
        begin
            m_era = evt.except ? evt.epc : wr.data;
            era_known = '1;
        end
        if (wr.en && wr.addr == EENTRY)
        begin
            m_eentry = wr.data & 32'hffff_ffc0;
            eentry_known = '1;
        end
        for (int i = 0; i < 4; i++)
        begin
            if (wr.en && wr.addr == (SAVE0 + i))
            begin
                m_save[i] = wr.data;
                save_known[i] = '1;
            end
        end
        if (wr.en && wr.addr == TID)
            m_tid = wr.data;
        if (wr.en && wr.addr == TICLR && wr.data[0])
            m_irq = 1'b0;
        else if (expire)
            m_irq = 1'b1;
        if (wr.en && wr.addr == TCFG)
        begin
            m_tcfg = wr.data;
            m_en = wr.data[0];
            m_tval = wr.data & 32'hffff_fffc;
            tval_known = '1;
        end
        else if (expire)
        begin
            m_en = old_tcfg[1];
            m_tval = old_tcfg[1] ? (old_tcfg & 32'hffff_fffc) : '1;
        end
        else if (m_en)
            m_tval = m_tval - 32'd1;
    endtask

    always @(posedge clk)
    begin
        if (test_num != cur_test)
        begin
            if (cur_test != 0)
            begin
                tests_done++;
                $display("test %0d %s: %0d checks, %0d errors", cur_test,
                         test_name(cur_test), test_checks, test_errors);
            end
            cur_test = test_num;
            test_checks = 0;
            test_errors = 0;
        end
        if (finished && !reported)
        begin
            $display("summary: %0d tests, %0d checks, %0d errors", tests_done,
                     check_count, error_count);
            reported = 1'b1;
        end
        if (rst)
            reset_model();
        else
        begin
            compare_outputs();
            update_model();
        end
    end

endmodule

/* testbench/tb_csr.sv */
`timescale 1ns/1ps

module tb_csr;
    import csr_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 64;
    localparam int NUM_ADDRS    = 18;
    localparam int IRQ_STEPS    = 48;
    localparam int LEN_RESET    = 10;
    localparam int LEN_ACCESS   = 4 * NUM_ADDRS + 8;
    localparam int LEN_TRAP     = 4 * 10 + 2;
    localparam int LEN_IRQ      = IRQ_STEPS + 4;
    localparam int LEN_TIMER    = 4 * WAIT_LIMIT + 40;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + LEN_RESET + LEN_ACCESS + LEN_TRAP
                                  + LEN_IRQ + LEN_TIMER + 100;

    // kept addresses followed by a few unmapped ones
    localparam logic [CSR_ADDR_W-1:0] ACCESS_ADDRS [NUM_ADDRS] = '{
        CRMD, PRMD, ECFG, ESTAT, ERA, EENTRY, SAVE0, SAVE1, SAVE2, SAVE3,
        TID, TCFG, TVAL, TICLR, 14'h0002, 14'h0035, 14'h0043, 14'h3fff
    };

    logic              clk;
    logic              rst;
    csr_addr_e         raddr;
    csr_wr_t           wr;
    trap_event_t       evt;
    logic [HWI_W-1:0]  hwi;
    logic              ipi;
    logic [DATA_W-1:0] rdata;
    logic              is_interrupt;
    logic [DATA_W-1:0] trap_entry;
    logic [DATA_W-1:0] era_out;
    logic [DATA_W-1:0] crmd_out;
    int                test_num;
    logic              finished;
    int                error_count;
    int                wait_fail;
    int                cycle_count;
    logic [31:0]       lfsr_state;

    csr_unit dut0 (
        .clk          (clk),
        .rst          (rst),
        .raddr        (raddr),
        .rdata        (rdata),
        .wr           (wr),
        .evt          (evt),
        .hwi          (hwi),
        .ipi          (ipi),
        .is_interrupt (is_interrupt),
        .trap_entry   (trap_entry),
        .era_out      (era_out),
        .crmd_out     (crmd_out)
    );

    csr_checker chk0 (
        .clk          (clk),
        .rst          (rst),
        .raddr        (raddr),
        .wr           (wr),
        .evt          (evt),
        .hwi          (hwi),
        .ipi          (ipi),
        .rdata        (rdata),
        .is_interrupt (is_interrupt),
        .trap_entry   (trap_entry),
        .era_out      (era_out),
        .crmd_out     (crmd_out),
        .test_num     (test_num),
        .finished     (finished),
        .error_count  (error_count)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task start_test(input int n);
        @(negedge clk);
        wr.en = 1'b0;
        evt.except = 1'b0;
        evt.ertn = 1'b0;
        test_num = n;
    endtask

    task drive_write(input logic [CSR_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge clk);
        wr.en = 1'b1;
        wr.addr = addr;
        wr.data = data;
        evt.except = 1'b0;
        evt.ertn = 1'b0;
    endtask

    task drive_read(input logic [CSR_ADDR_W-1:0] addr);
        @(negedge clk);
        wr.en = 1'b0;
        evt.except = 1'b0;
        evt.ertn = 1'b0;
        raddr = csr_addr_e'(addr);
    endtask

    // an optional era write in the same cycle loses to the exception
    task raise_exception(input logic with_write);
        logic [31:0] r;
        @(negedge clk);
        evt.except = 1'b1;
        evt.ertn = 1'b0;
        evt.epc = rand_bits(DATA_W);
        r = rand_bits(ECODE_W);
        evt.ecode = r[ECODE_W-1:0];
        r = rand_bits(ESUBCODE_W);
        evt.esubcode = r[ESUBCODE_W-1:0];
        wr.en = with_write;
        wr.addr = ERA;
        wr.data = rand_bits(DATA_W);
        raddr = ERA;
    endtask

    task return_from_exception;
        @(negedge clk);
        wr.en = 1'b0;
        evt.except = 1'b0;
        evt.ertn = 1'b1;
        raddr = CRMD;
    endtask

    // samples rdata at the rising edge until it matches
    task wait_for_value(input logic [CSR_ADDR_W-1:0] addr, input logic [DATA_W-1:0] mask,
                        input logic [DATA_W-1:0] value, input string what);
        int n;
        drive_read(addr);
        n = 0;
        @(posedge clk);
        while (((rdata & mask) !== value) && (n < WAIT_LIMIT))
        begin
            @(posedge clk);
            n++;
        end
        if ((rdata & mask) !== value)
        begin
            $display("%s did not happen within %0d cycles", what, WAIT_LIMIT);
            wait_fail++;
        end
    endtask

    task read_reset_values;
        start_test(1);
        drive_read(CRMD);
        drive_read(PRMD);
        drive_read(ECFG);
        drive_read(ESTAT);
        drive_read(TCFG);
        drive_read(TID);
        drive_read(EENTRY);
        drive_read(TICLR);
    endtask

    task sweep_register_access;
        start_test(2);
        for (int round = 0; round < 2; round++)
        begin
            for (int i = 0; i < NUM_ADDRS; i++)
            begin
                drive_write(ACCESS_ADDRS[i], rand_bits(DATA_W));
                drive_read(ACCESS_ADDRS[i]);
            end
        end
        drive_write(TCFG, 32'd0);
        drive_write(TICLR, 32'd1);
        drive_read(ESTAT);
    endtask

    task raise_and_return;
        logic [31:0] r;
        start_test(3);
        for (int i = 0; i < 4; i++)
        begin
            drive_write(CRMD, rand_bits(DATA_W));
            drive_write(PRMD, rand_bits(DATA_W));
            drive_write(EENTRY, rand_bits(DATA_W));
            r = rand_bits(1);
            raise_exception(r[0]);
            drive_read(ESTAT);
            drive_read(PRMD);
            return_from_exception();
            drive_read(CRMD);
            drive_read(ERA);
        end
    endtask

    task drive_interrupt_lines;
        logic [31:0] r;
        start_test(4);
        for (int i = 0; i < IRQ_STEPS; i++)
        begin
            @(negedge clk);
            r = rand_bits(HWI_W);
            hwi = r[HWI_W-1:0];
            r = rand_bits(1);
            ipi = r[0];
            // write only when bit 1 is low
            // bit 0 picks crmd or ecfg
            r = rand_bits(2);
            wr.en = !r[1];
            wr.addr = r[0] ? CRMD : ECFG;
            wr.data = rand_bits(DATA_W);
            raddr = ESTAT;
        end
        @(negedge clk);
        wr.en = 1'b0;
        hwi = '0;
        ipi = 1'b0;
    endtask

    task run_timer_modes;
        logic [31:0] count;
        start_test(5);
        count = rand_bits(3) + 32'd2;
        drive_write(TICLR, 32'd1);
        drive_write(TCFG, (count << 2) | 32'd1);
        wait_for_value(TVAL, '1, '0, "one-shot countdown to zero");
        drive_read(ESTAT);
        drive_read(ESTAT);
        drive_read(ESTAT);
        drive_read(TVAL);
        drive_read(TCFG);
        count = rand_bits(3) + 32'd2;
        drive_write(TICLR, 32'd1);
        drive_write(TCFG, (count << 2) | 32'd3);
        wait_for_value(ESTAT, 32'h800, 32'h800, "first periodic interrupt");
        drive_read(TVAL);
        drive_write(TICLR, 32'd1);
        wait_for_value(ESTAT, 32'h800, 32'h0, "interrupt clear");
        wait_for_value(ESTAT, 32'h800, 32'h800, "second periodic interrupt");
        drive_write(TCFG, 32'd0);
        drive_write(TICLR, 32'd1);
        drive_read(TVAL);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        rst = 1'b1;
        raddr = CRMD;
        wr = '0;
        evt = '0;
        hwi = '0;
        ipi = 1'b0;
        test_num = 0;
        finished = 1'b0;
        wait_fail = 0;
        lfsr_state = 32'hcd42;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        read_reset_values();
        sweep_register_access();
        raise_and_return();
        drive_interrupt_lines();
        run_timer_modes();
        @(negedge clk);
        wr.en = 1'b0;
        test_num = 0;
        finished = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (error_count == 0 && wait_fail == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* all.f */
common/csr_pkg.sv
design/csr_access.sv
trap/csr_trap.sv
timer/csr_timer.sv
design/csr_unit.sv
testbench/csr_checker.sv
testbench/tb_csr.sv

/* run.sh */
#!/usr/bin/env bash
# builds the CSR testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_csr -f all.f -o sim_csr

./obj_dir/sim_csr | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished, see sim.log"
